//--- lsuDefines.svh
// sizing and encoding macros for the load execution path
// included by the package and by every module that sizes a port

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// store queue and load queue share one depth
`define LSQ_DEPTH       16
`define LSQ_INDEX       4

// address and data widths
`define VIRT_ADDR_W     32
`define DATA_W          32

// byte offset inside one data word
`define BYTE_OFF_W      2

// size code of a load or store
`define LDST_SIZE_W     2

// lanes written by dispatch each cycle
`define DISPATCH_WIDTH  2

// sequence number carried with a violating load
`define SEQ_NO_W        8

// access size codes, wider access has the larger code
`define LDST_BYTE       2'd0
`define LDST_HALF       2'd1
`define LDST_WORD       2'd2

`endif

//--- lsuPkg.sv
// shared types of the load execution path
// modules pull these in with a wildcard import in their header

`include "lsuDefines.svh"

package lsuPkg;

	// index into the store queue or the load queue
	typedef logic [`LSQ_INDEX-1:0] lsqIdx_t;

	// one bit per queue entry
	typedef logic [`LSQ_DEPTH-1:0] lsqVec_t;

	// full virtual address
	typedef logic [`VIRT_ADDR_W-1:0] virtAddr_t;

	// word part of an address, matched by the word array
	typedef logic [`VIRT_ADDR_W-`BYTE_OFF_W-1:0] wordAddr_t;

	// byte offset inside the word
	typedef logic [`BYTE_OFF_W-1:0] byteOff_t;

	// one data word
	typedef logic [`DATA_W-1:0] data_t;

	// access size code
	typedef logic [`LDST_SIZE_W-1:0] ldstSize_t;

	// comparison done by a match array
	// greater flags entries whose tag is below the compare tag
	typedef enum logic
	{
		CAM_EQUAL,
		CAM_GREATER
	} camMode_t;

endpackage

//--- stqCam.sv
// content-addressable match array over the store queue entries
// one write port at the store's index and one compare port for the load
// payload type and comparison mode are set per instance

`timescale 1ns/100ps

`include "lsuDefines.svh"

module stqCam
	import lsuPkg::*;
#(
	parameter type      tagType = wordAddr_t,
	parameter camMode_t MODE    = CAM_EQUAL
)
(
	input  logic    clk,

	// store execute writes its tag
	input  logic    wrEn_i,
	input  lsqIdx_t wrIdx_i,
	input  tagType  wrTag_i,

	// load tag compared against every entry
	input  tagType  cmpTag_i,
	output lsqVec_t match_o
);

	// stored tags, validity is tracked by the store queue
	tagType tagMem [`LSQ_DEPTH];

	// tag lands at the edge after the strobe
	always_ff @(posedge clk)
	begin
		if (wrEn_i)
		begin
			tagMem[wrIdx_i] <= wrTag_i;
		end
	end

	// compare all entries in parallel
	always_comb
	begin
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			if (MODE == CAM_GREATER)
			begin
				// entry narrower than the load
				match_o[i] = (tagMem[i] < cmpTag_i);
			end
			else
			begin
				match_o[i] = (tagMem[i] == cmpTag_i);
			end
		end
	end

endmodule

//--- storeQueue.sv
// store queue storage: address, data and size per entry plus address-valid bits
// three match arrays compare the executing load against all stores
// read ports give the head entry for commit and the forwarded store's data

`timescale 1ns/100ps

`include "lsuDefines.svh"

module storeQueue
	import lsuPkg::*;
(
	input  logic      clk,
	input  logic      reset,

	// recovery reloads the address-valid bits
	input  logic      recoverFlag_i,
	input  lsqVec_t   stqAddrValidRecover_i,

	// store execute
	input  logic      stValid_i,
	input  lsqIdx_t   stLsqId_i,
	input  virtAddr_t stAddr_i,
	input  data_t     stData_i,
	input  ldstSize_t stSize_i,

	// commit of the head store
	input  logic      commitSt_i,
	input  lsqIdx_t   stqHead_i,

	// executing load
	input  virtAddr_t ldAddr_i,
	input  ldstSize_t ldSize_i,
	input  lsqIdx_t   fwdIdx_i,

	output lsqVec_t   wordMatch_o,
	output lsqVec_t   offMatch_o,
	output lsqVec_t   sizeGreater_o,
	output lsqVec_t   addrValid_o,
	output data_t     fwdData_o,

	// head entry for the memory side
	output virtAddr_t stCommitAddr_o,
	output data_t     stCommitData_o,
	output ldstSize_t stCommitSize_o
);

	// payload, one write port and two read ports
	virtAddr_t stAddrMem [`LSQ_DEPTH];
	data_t     stDataMem [`LSQ_DEPTH];
	ldstSize_t stSizeMem [`LSQ_DEPTH];

	lsqVec_t   addrValid;

	always_ff @(posedge clk)
	begin
		if (stValid_i)
		begin
			stAddrMem[stLsqId_i] <= stAddr_i;
			stDataMem[stLsqId_i] <= stData_i;
			stSizeMem[stLsqId_i] <= stSize_i;
		end
	end

	// recovery first, then commit clear, then execute set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addrValid <= '0;
		end
		else if (recoverFlag_i)
		begin
			addrValid <= stqAddrValidRecover_i;
		end
		else
		begin
			if (commitSt_i)
			begin
				addrValid[stqHead_i] <= 1'b0;
			end
			if (stValid_i)
			begin
				addrValid[stLsqId_i] <= 1'b1;
			end
		end
	end

	assign addrValid_o = addrValid;

	// word address match
	stqCam #(.tagType(wordAddr_t), .MODE(CAM_EQUAL)) u_wordCam (
		.clk      (clk),
		.wrEn_i   (stValid_i),
		.wrIdx_i  (stLsqId_i),
		.wrTag_i  (stAddr_i[`VIRT_ADDR_W-1:`BYTE_OFF_W]),
		.cmpTag_i (ldAddr_i[`VIRT_ADDR_W-1:`BYTE_OFF_W]),
		.match_o  (wordMatch_o)
	);

	// byte offset match
	stqCam #(.tagType(byteOff_t), .MODE(CAM_EQUAL)) u_offCam (
		.clk      (clk),
		.wrEn_i   (stValid_i),
		.wrIdx_i  (stLsqId_i),
		.wrTag_i  (stAddr_i[`BYTE_OFF_W-1:0]),
		.cmpTag_i (ldAddr_i[`BYTE_OFF_W-1:0]),
		.match_o  (offMatch_o)
	);

	// stores smaller than the load
	stqCam #(.tagType(ldstSize_t), .MODE(CAM_GREATER)) u_sizeCam (
		.clk      (clk),
		.wrEn_i   (stValid_i),
		.wrIdx_i  (stLsqId_i),
		.wrTag_i  (stSize_i),
		.cmpTag_i (ldSize_i),
		.match_o  (sizeGreater_o)
	);

	// forward read at the youngest full match
	assign fwdData_o      = stDataMem[fwdIdx_i];

	// commit read at the head
	assign stCommitAddr_o = stAddrMem[stqHead_i];
	assign stCommitData_o = stDataMem[stqHead_i];
	assign stCommitSize_o = stSizeMem[stqHead_i];

endmodule

//--- ldqLastStore.sv
// per load queue entry: index of the youngest older store, its valid bit
// and the predicted-violation bit, written at dispatch and read by the executing load

`timescale 1ns/100ps

`include "lsuDefines.svh"

module ldqLastStore
	import lsuPkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       recoverFlag_i,

	// dispatch lanes
	input  logic                       dispatchReady_i,
	input  logic [`DISPATCH_WIDTH-1:0] dispIsLoad_i,
	input  logic [`DISPATCH_WIDTH-1:0] dispIsStore_i,
	input  lsqIdx_t                    dispLdqId_i [`DISPATCH_WIDTH],
	input  lsqIdx_t                    dispLastSt_i [`DISPATCH_WIDTH],
	input  logic [`DISPATCH_WIDTH-1:0] dispPredVio_i,

	// store commit and queue occupancy
	input  logic                       commitSt_i,
	input  lsqIdx_t                    stqHead_i,
	input  logic [`LSQ_INDEX:0]        stqCount_i,

	// load retirement
	input  logic                       commitLd_i,
	input  lsqIdx_t                    commitLdIndex_i,

	// read for the executing load
	input  lsqIdx_t                    ldLsqId_i,
	output lsqIdx_t                    lastSt_o,
	output logic                       lastStValid_o,
	output logic                       predVio_o
);

	lsqIdx_t             lastStMem [`LSQ_DEPTH];
	lsqVec_t             lastStValidMem;
	lsqVec_t             lastStValidNext;
	lsqVec_t             predVioMem;
	logic [`LSQ_INDEX:0] countAfterCommit;
	logic                stqEmpty;
	logic                olderStore;

	always_comb
	begin
		// queue empty once this cycle's commit is done
		countAfterCommit = stqCount_i - {{`LSQ_INDEX{1'b0}}, commitSt_i};
		stqEmpty         = (countAfterCommit == '0);
		olderStore       = 1'b0;
		lastStValidNext  = lastStValidMem;

		// committing store no longer needs checking
		if (commitSt_i)
		begin
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				if (lastStMem[i] == stqHead_i)
				begin
					lastStValidNext[i] = 1'b0;
				end
			end
		end

		// a load has an older store if the queue keeps one
		// or an earlier lane brings one
		if (dispatchReady_i)
		begin
			for (int l = 0; l < `DISPATCH_WIDTH; l++)
			begin
				if (dispIsLoad_i[l] && (!stqEmpty || olderStore))
				begin
					lastStValidNext[dispLdqId_i[l]] = 1'b1;
				end
				olderStore = olderStore | dispIsStore_i[l];
			end
		end

		// retiring load drops its entry
		if (commitLd_i)
		begin
			lastStValidNext[commitLdIndex_i] = 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lastStValidMem <= '0;
			predVioMem     <= '0;
		end
		else if (recoverFlag_i)
		begin
			lastStValidMem <= '0;
		end
		else
		begin
			lastStValidMem <= lastStValidNext;
			for (int l = 0; l < `DISPATCH_WIDTH; l++)
			begin
				if (dispatchReady_i && dispIsLoad_i[l])
				begin
					predVioMem[dispLdqId_i[l]] <= dispPredVio_i[l];
				end
			end
			if (commitLd_i)
			begin
				predVioMem[commitLdIndex_i] <= 1'b0;
			end
		end
	end

	// store index itself, meaningful only with its valid bit
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < `DISPATCH_WIDTH; l++)
		begin
			if (!recoverFlag_i && dispatchReady_i && dispIsLoad_i[l])
			begin
				lastStMem[dispLdqId_i[l]] <= dispLastSt_i[l];
			end
		end
	end

	assign lastSt_o      = lastStMem[ldLsqId_i];
	assign lastStValid_o = lastStValidMem[ldLsqId_i];
	assign predVio_o     = predVioMem[ldLsqId_i];

endmodule

//--- loadDisambig.sv
// load disambiguation against older stores, purely combinational
// picks the youngest fully matching store for forwarding, flags partial overlaps
// and stalls predicted-violating loads while an older store address is unknown

`timescale 1ns/100ps

`include "lsuDefines.svh"

module loadDisambig
	import lsuPkg::*;
(
	input  logic                ldValid_i,

	// last-store table entry of this load
	input  lsqIdx_t             lastSt_i,
	input  logic                lastStValid_i,
	input  logic                predVio_i,

	// store queue occupancy
	input  lsqIdx_t             stqHead_i,
	input  lsqIdx_t             stqTail_i,
	input  logic [`LSQ_INDEX:0] stqCount_i,

	// match arrays and address-valid bits
	input  lsqVec_t             wordMatch_i,
	input  lsqVec_t             offMatch_i,
	input  lsqVec_t             sizeGreater_i,
	input  lsqVec_t             addrValid_i,

	input  data_t               fwdData_i,
	input  data_t               memData_i,
	input  logic                memDataValid_i,

	output lsqIdx_t             fwdIdx_o,
	output data_t               loadData_o,
	output logic                loadDataValid_o,
	output logic                violation_o
);

	logic    lastStInRange;
	logic    stqWrap;
	lsqVec_t window;
	lsqVec_t fullVec;
	lsqVec_t partVec;
	logic    stqHit;
	logic    partialMatch;
	logic    disambigStall;
	lsqIdx_t lastMatch;
	lsqIdx_t idx;

	always_comb
	begin
		// lastSt must sit in the occupied part of the queue
		// tail at or below head is wrapped or full, count rules out empty
		lastStInRange = ((stqHead_i < stqTail_i) && (lastSt_i >= stqHead_i) &&
		                 (lastSt_i < stqTail_i)) ||
		                ((stqTail_i <= stqHead_i) && (stqCount_i != '0) &&
		                 ((lastSt_i < stqTail_i) || (lastSt_i >= stqHead_i)));

		stqWrap = (stqHead_i > lastSt_i);

		// stores from head up to lastSt are older than the load
		for (int i = 0; i < `LSQ_DEPTH; i++)
		begin
			if (!lastStInRange)
			begin
				window[i] = 1'b0;
			end
			else if (stqWrap)
			begin
				window[i] = (lsqIdx_t'(i) <= lastSt_i) || (lsqIdx_t'(i) >= stqHead_i);
			end
			else
			begin
				window[i] = (lsqIdx_t'(i) >= stqHead_i) && (lsqIdx_t'(i) <= lastSt_i);
			end
		end

		// same word and same offset can forward
		fullVec = addrValid_i & window & wordMatch_i & offMatch_i;
		// same word but other bytes or too few bytes
		partVec = addrValid_i & window & wordMatch_i & (~offMatch_i | sizeGreater_i);

		stqHit        = 1'b0;
		partialMatch  = 1'b0;
		disambigStall = 1'b0;
		lastMatch     = '0;
		idx           = '0;

		// oldest to youngest, later full match overrides earlier partial
		if (ldValid_i && lastStValid_i)
		begin
			for (int i = 0; i < `LSQ_DEPTH; i++)
			begin
				idx = stqHead_i + lsqIdx_t'(i);
				if (fullVec[idx])
				begin
					stqHit       = 1'b1;
					lastMatch    = idx;
					partialMatch = 1'b0;
				end
				if (partVec[idx])
				begin
					partialMatch = 1'b1;
				end
				// unknown older address holds a predicted violator
				if (predVio_i && window[idx] && !addrValid_i[idx])
				begin
					disambigStall = 1'b1;
				end
			end
		end
	end

	assign fwdIdx_o        = lastMatch;
	assign loadData_o      = stqHit ? fwdData_i : memData_i;
	assign loadDataValid_o = ldValid_i && (stqHit || memDataValid_i) && !disambigStall;
	assign violation_o     = partialMatch;

endmodule

//--- ldExecPath.sv
// top of the load execution path
// store queue, last-store table and disambiguation around a same-cycle memory port

`timescale 1ns/100ps

`include "lsuDefines.svh"

module ldExecPath
	import lsuPkg::*;
(
	input  logic                       clk,
	input  logic                       reset,

	// store execute
	input  logic                       stValid_i,
	input  lsqIdx_t                    stLsqId_i,
	input  virtAddr_t                  stAddr_i,
	input  data_t                      stData_i,
	input  ldstSize_t                  stSize_i,

	// load execute
	input  logic                       ldValid_i,
	input  lsqIdx_t                    ldLsqId_i,
	input  virtAddr_t                  ldAddr_i,
	input  ldstSize_t                  ldSize_i,
	input  logic [`SEQ_NO_W-1:0]       ldSeqNo_i,

	// store queue state
	input  lsqIdx_t                    stqHead_i,
	input  lsqIdx_t                    stqTail_i,
	input  logic [`LSQ_INDEX:0]        stqCount_i,

	// dispatch
	input  logic                       dispatchReady_i,
	input  logic [`DISPATCH_WIDTH-1:0] dispIsLoad_i,
	input  logic [`DISPATCH_WIDTH-1:0] dispIsStore_i,
	input  lsqIdx_t                    dispLdqId_i [`DISPATCH_WIDTH],
	input  lsqIdx_t                    dispLastSt_i [`DISPATCH_WIDTH],
	input  logic [`DISPATCH_WIDTH-1:0] dispPredVio_i,

	// commit and retire
	input  logic                       commitSt_i,
	input  logic                       commitLd_i,
	input  lsqIdx_t                    commitLdIndex_i,

	// recovery
	input  logic                       recoverFlag_i,
	input  lsqVec_t                    stqAddrValidRecover_i,

	// memory port, answers in the same cycle
	input  data_t                      memData_i,
	input  logic                       memDataValid_i,
	output virtAddr_t                  memAddr_o,
	output logic                       memEn_o,

	output data_t                      loadData_o,
	output logic                       loadDataValid_o,
	output logic                       ldVioValid_o,
	output logic [`SEQ_NO_W-1:0]       ldVioSeqNo_o,

	output virtAddr_t                  stCommitAddr_o,
	output data_t                      stCommitData_o,
	output ldstSize_t                  stCommitSize_o
);

	lsqVec_t wordMatch;
	lsqVec_t offMatch;
	lsqVec_t sizeGreater;
	lsqVec_t addrValid;
	data_t   fwdData;
	lsqIdx_t fwdIdx;
	lsqIdx_t lastSt;
	logic    lastStValid;
	logic    predVio;

	storeQueue u_storeQueue (
		.clk                   (clk),
		.reset                 (reset),
		.recoverFlag_i         (recoverFlag_i),
		.stqAddrValidRecover_i (stqAddrValidRecover_i),
		.stValid_i             (stValid_i),
		.stLsqId_i             (stLsqId_i),
		.stAddr_i              (stAddr_i),
		.stData_i              (stData_i),
		.stSize_i              (stSize_i),
		.commitSt_i            (commitSt_i),
		.stqHead_i             (stqHead_i),
		.ldAddr_i              (ldAddr_i),
		.ldSize_i              (ldSize_i),
		.fwdIdx_i              (fwdIdx),
		.wordMatch_o           (wordMatch),
		.offMatch_o            (offMatch),
		.sizeGreater_o         (sizeGreater),
		.addrValid_o           (addrValid),
		.fwdData_o             (fwdData),
		.stCommitAddr_o        (stCommitAddr_o),
		.stCommitData_o        (stCommitData_o),
		.stCommitSize_o        (stCommitSize_o)
	);

	ldqLastStore u_ldqLastStore (
		.clk             (clk),
		.reset           (reset),
		.recoverFlag_i   (recoverFlag_i),
		.dispatchReady_i (dispatchReady_i),
		.dispIsLoad_i    (dispIsLoad_i),
		.dispIsStore_i   (dispIsStore_i),
		.dispLdqId_i     (dispLdqId_i),
		.dispLastSt_i    (dispLastSt_i),
		.dispPredVio_i   (dispPredVio_i),
		.commitSt_i      (commitSt_i),
		.stqHead_i       (stqHead_i),
		.stqCount_i      (stqCount_i),
		.commitLd_i      (commitLd_i),
		.commitLdIndex_i (commitLdIndex_i),
		.ldLsqId_i       (ldLsqId_i),
		.lastSt_o        (lastSt),
		.lastStValid_o   (lastStValid),
		.predVio_o       (predVio)
	);

	loadDisambig u_loadDisambig (
		.ldValid_i       (ldValid_i),
		.lastSt_i        (lastSt),
		.lastStValid_i   (lastStValid),
		.predVio_i       (predVio),
		.stqHead_i       (stqHead_i),
		.stqTail_i       (stqTail_i),
		.stqCount_i      (stqCount_i),
		.wordMatch_i     (wordMatch),
		.offMatch_i      (offMatch),
		.sizeGreater_i   (sizeGreater),
		.addrValid_i     (addrValid),
		.fwdData_i       (fwdData),
		.memData_i       (memData_i),
		.memDataValid_i  (memDataValid_i),
		.fwdIdx_o        (fwdIdx),
		.loadData_o      (loadData_o),
		.loadDataValid_o (loadDataValid_o),
		.violation_o     (ldVioValid_o)
	);

	// memory read runs beside the store queue search
	assign memAddr_o    = ldAddr_i;
	assign memEn_o      = ldValid_i;
	assign ldVioSeqNo_o = ldSeqNo_i;

endmodule

//--- ldExecPath_tb.sv
// testbench for the load execution path
// drives stores, dispatch, loads, commits and recovery into the DUT
// and checks every load against a reference model of the store queue

`timescale 1ns/100ps

`include "lsuDefines.svh"

module ldExecPath_tb
	import lsuPkg::*;
();

	// rough length of all tests in cycles
	localparam int TEST_CYCLES = 120;

	logic                       clk = 1'b0;
	logic                       reset = 1'b1;
	logic                       stValid = 1'b0;
	lsqIdx_t                    stLsqId = '0;
	virtAddr_t                  stAddr = '0;
	data_t                      stData = '0;
	ldstSize_t                  stSize = '0;
	logic                       ldValid = 1'b0;
	lsqIdx_t                    ldLsqId = '0;
	virtAddr_t                  ldAddr = '0;
	ldstSize_t                  ldSize = '0;
	logic [`SEQ_NO_W-1:0]       ldSeqNo = '0;
	lsqIdx_t                    stqHead = '0;
	lsqIdx_t                    stqTail = '0;
	logic [`LSQ_INDEX:0]        stqCount = '0;
	logic                       dispatchReady = 1'b0;
	logic [`DISPATCH_WIDTH-1:0] dispIsLoad = '0;
	logic [`DISPATCH_WIDTH-1:0] dispIsStore = '0;
	lsqIdx_t                    dispLdqId [`DISPATCH_WIDTH];
	lsqIdx_t                    dispLastSt [`DISPATCH_WIDTH];
	logic [`DISPATCH_WIDTH-1:0] dispPredVio = '0;
	logic                       commitSt = 1'b0;
	logic                       commitLd = 1'b0;
	lsqIdx_t                    commitLdIndex = '0;
	logic                       recoverFlag = 1'b0;
	lsqVec_t                    recoverVec = '0;
	data_t                      memData = '0;
	logic                       memDataValid = 1'b1;

	virtAddr_t                  memAddr_o;
	logic                       memEn_o;
	data_t                      loadData_o;
	logic                       loadDataValid_o;
	logic                       ldVioValid_o;
	logic [`SEQ_NO_W-1:0]       ldVioSeqNo_o;
	virtAddr_t                  stCommitAddr_o;
	data_t                      stCommitData_o;
	ldstSize_t                  stCommitSize_o;

	// reference model state
	virtAddr_t refAddr [`LSQ_DEPTH];
	data_t     refData [`LSQ_DEPTH];
	ldstSize_t refSize [`LSQ_DEPTH];
	lsqVec_t   refValid;
	lsqIdx_t   refLastSt [`LSQ_DEPTH];
	lsqVec_t   refLastStValid;
	lsqVec_t   refPredVio;

	// bookkeeping
	integer               seed = 86898;
	int                   errorCount = 0;
	int                   checkCount = 0;
	string                testName = "reset";
	logic                 checkCommit = 1'b0;
	data_t                expData;
	logic                 expValid;
	logic                 expVio;
	wordAddr_t            words [3];
	data_t                sentData [`LSQ_DEPTH];
	virtAddr_t            addr;
	lsqIdx_t              ldq;
	ldstSize_t            size;
	int                   pick;
	logic [`SEQ_NO_W-1:0] seqCount = '0;

	ldExecPath u_ldExecPath (
		.clk                   (clk),
		.reset                 (reset),
		.stValid_i             (stValid),
		.stLsqId_i             (stLsqId),
		.stAddr_i              (stAddr),
		.stData_i              (stData),
		.stSize_i              (stSize),
		.ldValid_i             (ldValid),
		.ldLsqId_i             (ldLsqId),
		.ldAddr_i              (ldAddr),
		.ldSize_i              (ldSize),
		.ldSeqNo_i             (ldSeqNo),
		.stqHead_i             (stqHead),
		.stqTail_i             (stqTail),
		.stqCount_i            (stqCount),
		.dispatchReady_i       (dispatchReady),
		.dispIsLoad_i          (dispIsLoad),
		.dispIsStore_i         (dispIsStore),
		.dispLdqId_i           (dispLdqId),
		.dispLastSt_i          (dispLastSt),
		.dispPredVio_i         (dispPredVio),
		.commitSt_i            (commitSt),
		.commitLd_i            (commitLd),
		.commitLdIndex_i       (commitLdIndex),
		.recoverFlag_i         (recoverFlag),
		.stqAddrValidRecover_i (recoverVec),
		.memData_i             (memData),
		.memDataValid_i        (memDataValid),
		.memAddr_o             (memAddr_o),
		.memEn_o               (memEn_o),
		.loadData_o            (loadData_o),
		.loadDataValid_o       (loadDataValid_o),
		.ldVioValid_o          (ldVioValid_o),
		.ldVioSeqNo_o          (ldVioSeqNo_o),
		.stCommitAddr_o        (stCommitAddr_o),
		.stCommitData_o        (stCommitData_o),
		.stCommitSize_o        (stCommitSize_o)
	);

	always #4 clk = ~clk;

	// memory contents as a fixed scramble of the address
	function automatic data_t memModel(input virtAddr_t a);
		return {a[15:0], a[31:16]} ^ 32'hc3a5_9e17;
	endfunction

	// expected result of a load from the model state
	function automatic void refLoad(input lsqIdx_t ldqIdx, input virtAddr_t a,
		input ldstSize_t sz, input lsqIdx_t head, input logic [`LSQ_INDEX:0] count,
		input data_t memWord, output data_t data, output logic dataValid, output logic vio);
		lsqIdx_t span;
		lsqIdx_t pos;
		logic    hit;
		logic    stall;
		data_t   fwd;
		hit   = 1'b0;
		stall = 1'b0;
		vio   = 1'b0;
		fwd   = '0;
		// distance from head to the last older store
		span  = refLastSt[ldqIdx] - head;
		if (refLastStValid[ldqIdx] && (span < count))
		begin
			// walk oldest to youngest
			// a younger full match hides older overlaps
			for (int k = 0; k <= span; k++)
			begin
				pos = lsqIdx_t'(head + k);
				if (!refValid[pos])
				begin
					stall = stall | refPredVio[ldqIdx];
				end
				else if (refAddr[pos][`VIRT_ADDR_W-1:`BYTE_OFF_W] ==
				         a[`VIRT_ADDR_W-1:`BYTE_OFF_W])
				begin
					if (refAddr[pos][`BYTE_OFF_W-1:0] == a[`BYTE_OFF_W-1:0])
					begin
						hit = 1'b1;
						fwd = refData[pos];
						vio = 1'b0;
					end
					// other bytes of the word or a store too narrow
					if ((refAddr[pos][`BYTE_OFF_W-1:0] != a[`BYTE_OFF_W-1:0]) ||
					    (refSize[pos] < sz))
					begin
						vio = 1'b1;
					end
				end
			end
		end
		data      = hit ? fwd : memWord;
		dataValid = (hit || memDataValid) && !stall;
	endfunction

	task automatic checkValue(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
		end
	endtask

	// model follows the same edges as the DUT registers
	always @(posedge clk or posedge reset)
	begin : modelUpdate
		logic                olderSt;
		logic [`LSQ_INDEX:0] remaining;
		if (reset)
		begin
			refValid       = '0;
			refLastStValid = '0;
			refPredVio     = '0;
		end
		else
		begin
			if (stValid)
			begin
				refAddr[stLsqId] = stAddr;
				refData[stLsqId] = stData;
				refSize[stLsqId] = stSize;
			end
			if (recoverFlag)
			begin
				refValid       = recoverVec;
				refLastStValid = '0;
			end
			else
			begin
				if (commitSt)
				begin
					refValid[stqHead] = 1'b0;
					for (int i = 0; i < `LSQ_DEPTH; i++)
					begin
						if (refLastSt[i] == stqHead)
						begin
							refLastStValid[i] = 1'b0;
						end
					end
				end
				if (stValid)
				begin
					refValid[stLsqId] = 1'b1;
				end
				// older store exists if the queue keeps one or an earlier lane adds one
				remaining = stqCount - commitSt;
				olderSt   = 1'b0;
				for (int l = 0; l < `DISPATCH_WIDTH; l++)
				begin
					if (dispatchReady && dispIsLoad[l])
					begin
						refLastSt[dispLdqId[l]]  = dispLastSt[l];
						refPredVio[dispLdqId[l]] = dispPredVio[l];
						if ((remaining != '0) || olderSt)
						begin
							refLastStValid[dispLdqId[l]] = 1'b1;
						end
					end
					olderSt = olderSt | (dispatchReady & dispIsStore[l]);
				end
				if (commitLd)
				begin
					refLastStValid[commitLdIndex] = 1'b0;
					refPredVio[commitLdIndex]     = 1'b0;
				end
			end
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		checkValue(testName, "memory enable", ldValid, memEn_o);
		if (ldValid)
		begin
			refLoad(ldLsqId, ldAddr, ldSize, stqHead, stqCount, memData,
				expData, expValid, expVio);
			checkValue(testName, "memory address", ldAddr, memAddr_o);
			checkValue(testName, "data valid", expValid, loadDataValid_o);
			if (expValid)
			begin
				checkValue(testName, "load data", expData, loadData_o);
			end
			checkValue(testName, "violation", expVio, ldVioValid_o);
			if (expVio)
			begin
				checkValue(testName, "violation seqno", ldSeqNo, ldVioSeqNo_o);
			end
		end
		else
		begin
			checkValue(testName, "idle data valid", 1'b0, loadDataValid_o);
			checkValue(testName, "idle violation", 1'b0, ldVioValid_o);
		end
		if (checkCommit)
		begin
			checkValue(testName, "commit address", refAddr[stqHead], stCommitAddr_o);
			checkValue(testName, "commit data", refData[stqHead], stCommitData_o);
			checkValue(testName, "commit size", refSize[stqHead], stCommitSize_o);
		end
	end

	// each step starts on a rising edge with every strobe dropped
	task automatic startCycle();
		@(posedge clk);
		stValid       <= 1'b0;
		ldValid       <= 1'b0;
		dispatchReady <= 1'b0;
		dispIsLoad    <= '0;
		dispIsStore   <= '0;
		dispPredVio   <= '0;
		commitSt      <= 1'b0;
		commitLd      <= 1'b0;
		recoverFlag   <= 1'b0;
		checkCommit   <= 1'b0;
	endtask

	task automatic setQueue(input lsqIdx_t head, input lsqIdx_t tail,
		input logic [`LSQ_INDEX:0] count);
		startCycle();
		stqHead  <= head;
		stqTail  <= tail;
		stqCount <= count;
	endtask

	task automatic executeStore(input lsqIdx_t idx, input virtAddr_t a, input ldstSize_t sz);
		data_t d;
		d = $random(seed);
		sentData[idx] = d;
		startCycle();
		stValid <= 1'b1;
		stLsqId <= idx;
		stAddr  <= a;
		stData  <= d;
		stSize  <= sz;
	endtask

	// single load on lane 0
	task automatic dispatchLoad(input lsqIdx_t ldqIdx, input lsqIdx_t lastSt, input logic pv);
		startCycle();
		dispatchReady <= 1'b1;
		dispIsLoad    <= 2'b01;
		dispLdqId[0]  <= ldqIdx;
		dispLastSt[0] <= lastSt;
		dispPredVio   <= {1'b0, pv};
	endtask

	task automatic executeLoad(input lsqIdx_t ldqIdx, input virtAddr_t a, input ldstSize_t sz);
		startCycle();
		ldValid <= 1'b1;
		ldLsqId <= ldqIdx;
		ldAddr  <= a;
		ldSize  <= sz;
		ldSeqNo <= seqCount;
		memData <= memModel(a);
		seqCount++;
	endtask

	task automatic retireLoad(input lsqIdx_t ldqIdx);
		startCycle();
		commitLd      <= 1'b1;
		commitLdIndex <= ldqIdx;
	endtask

	// commit strobe for the head store while the head stays put
	task automatic commitStore();
		startCycle();
		commitSt    <= 1'b1;
		checkCommit <= 1'b1;
	endtask

	// head moves on once its store has left
	task automatic advanceHead();
		startCycle();
		stqHead  <= stqHead + 1'b1;
		stqCount <= stqCount - 1'b1;
	endtask

	task automatic recoverQueue(input lsqVec_t vec);
		startCycle();
		recoverFlag <= 1'b1;
		recoverVec  <= vec;
	endtask

	// watchdog
	initial
	begin
		#(TEST_CYCLES * 8 + 200);
		$display("timeout: the run did not reach its end in time");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		dispLdqId[0]  = '0;
		dispLdqId[1]  = '0;
		dispLastSt[0] = '0;
		dispLastSt[1] = '0;
		// stored words keep the top bit clear
		// miss addresses set it
		for (int i = 0; i < 3; i++)
		begin
			words[i] = $random(seed);
			words[i][`VIRT_ADDR_W-`BYTE_OFF_W-1] = 1'b0;
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// six stores over three words
		// the youngest match forwards
		testName = "forward";
		setQueue(0, 6, 6);
		for (int i = 0; i < 6; i++)
		begin
			executeStore(i, {words[i % 3], 2'b00}, `LDST_WORD);
		end
		dispatchLoad(0, 5, 1'b0);
		executeLoad(0, {words[0], 2'b00}, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "youngest store data", sentData[3], loadData_o);
		for (int n = 0; n < 10; n++)
		begin
			ldq  = $random(seed);
			pick = $unsigned($random(seed)) % 4;
			size = $unsigned($random(seed)) % 3;
			addr = (pick == 3) ? virtAddr_t'($random(seed)) : {words[pick], 2'b00};
			dispatchLoad(ldq, 5, 1'b0);
			executeLoad(ldq, addr, size);
		end

		testName = "no match";
		addr = {1'b1, words[1][`VIRT_ADDR_W-`BYTE_OFF_W-2:0], 2'b00};
		dispatchLoad(1, 5, 1'b0);
		executeLoad(1, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "memory data", memModel(addr), loadData_o);
		// retired load has no last store left
		addr = {words[0], 2'b00};
		dispatchLoad(2, 5, 1'b0);
		retireLoad(2);
		executeLoad(2, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "retired load data", memModel(addr), loadData_o);
		// window ending at store 2 has store 0 as youngest match
		dispatchLoad(3, 2, 1'b0);
		executeLoad(3, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "short window data", sentData[0], loadData_o);

		testName = "partial";
		setQueue(0, 8, 8);
		executeStore(6, {words[1], 2'b10}, `LDST_HALF);
		executeStore(7, {words[2], 2'b00}, `LDST_BYTE);
		dispatchLoad(4, 7, 1'b0);
		executeLoad(4, {words[1], 2'b00}, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "offset overlap", 1'b1, ldVioValid_o);
		executeLoad(4, {words[2], 2'b00}, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "narrow store", 1'b1, ldVioValid_o);
		executeLoad(4, {words[1], 2'b10}, `LDST_HALF);
		@(negedge clk);
		checkValue(testName, "half forward", sentData[6], loadData_o);

		// store 8 is allocated but its address is not known yet
		testName = "stall";
		setQueue(0, 9, 9);
		dispatchLoad(5, 8, 1'b1);
		executeLoad(5, {words[0], 2'b00}, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "stalled valid", 1'b0, loadDataValid_o);
		executeStore(8, {words[0], 2'b00}, `LDST_WORD);
		executeLoad(5, {words[0], 2'b00}, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "released valid", 1'b1, loadDataValid_o);
		checkValue(testName, "released data", sentData[8], loadData_o);

		testName = "commit";
		addr = {words[0], 2'b00};
		dispatchLoad(6, 0, 1'b0);
		executeLoad(6, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "before commit", sentData[0], loadData_o);
		commitStore();
		// head still on the committed entry
		// only the commit itself keeps the load off the store
		executeLoad(6, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "after commit", memModel(addr), loadData_o);
		advanceHead();
		commitStore();
		advanceHead();
		commitStore();
		advanceHead();

		testName = "recovery";
		dispatchLoad(7, 8, 1'b0);
		// word 0 stores at entries 3 and 8 stay valid
		// so a stale table entry would forward instead of reading memory
		recoverQueue(lsqVec_t'($random(seed) | (1 << 3) | (1 << 8)));
		executeLoad(7, addr, `LDST_WORD);
		@(negedge clk);
		checkValue(testName, "cleared table", memModel(addr), loadData_o);
		dispatchLoad(7, 8, 1'b0);
		for (int i = 0; i < 3; i++)
		begin
			executeLoad(7, {words[i], 2'b00}, `LDST_WORD);
		end
		executeLoad(7, {words[1], 2'b10}, `LDST_HALF);
		startCycle();
		startCycle();

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+.
lsuPkg.sv
stqCam.sv
storeQueue.sv
ldqLastStore.sv
loadDisambig.sv
ldExecPath.sv
ldExecPath_tb.sv

//--- Bender.yml
package:
  name: ld_exec_path

sources:
  - include_dirs:
      - .
    files:
      - lsuPkg.sv
      - stqCam.sv
      - storeQueue.sv
      - ldqLastStore.sv
      - loadDisambig.sv
      - ldExecPath.sv

  - target: test
    include_dirs:
      - .
    files:
      - ldExecPath_tb.sv
